/* alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// data path width in bits
`define ALU_XLEN 64

// physical register counts for the integer and flag files
`define ALU_NUM_PREGS 32
`define ALU_NUM_FLAG_REGS 8

// number of micro-ops the in-order issue queue can hold
`define ALU_IQ_DEPTH 8

// the reorder buffer size only sets the width of the completion pointer
`define ALU_ROB_ENTRIES 32

`endif

/* alu_pkg.sv */
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    typedef logic [`ALU_XLEN-1:0] word_t;
    typedef logic [$clog2(`ALU_NUM_PREGS)-1:0] preg_idx_t;
    typedef logic [$clog2(`ALU_NUM_FLAG_REGS)-1:0] flag_idx_t;
    typedef logic [$clog2(`ALU_ROB_ENTRIES)-1:0] rob_ptr_t;

    // bit 0 is N, bit 1 is Z, bit 2 is C and bit 3 is V
    typedef logic [3:0] nzcv_t;

    // for UBFM bits 5:0 hold the low bit position and bits 11:6 the high one
    typedef logic [15:0] imm_t;

    // halfword slot used by MOVZ and MOVK
    typedef logic [1:0] hw_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_orr,
        op_eor,
        op_mvn,
        op_ubfm,
        op_asr,
        op_movz,
        op_movk
    } alu_op_e;

    typedef enum logic [1:0] {
        iq_empty,
        iq_stall,
        iq_issue
    } iq_state_e;

endpackage

`default_nettype wire

/* alu_issue_queue.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"
`default_nettype none

module alu_issue_queue import alu_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  logic      disp_valid,
    input  alu_op_e   disp_op,
    input  logic      disp_imm_sel,
    input  imm_t      disp_imm,
    input  hw_t       disp_hw,
    input  logic      disp_set_nzcv,
    input  preg_idx_t disp_src1,
    input  preg_idx_t disp_src2,
    input  preg_idx_t disp_old_dest,
    input  preg_idx_t disp_dest,
    input  flag_idx_t disp_flag_src,
    input  flag_idx_t disp_flag_dest,
    input  rob_ptr_t  disp_rob_ptr,
    output logic      disp_ready,
    input  logic      wb_valid,
    input  preg_idx_t wb_dest,
    input  flag_idx_t wb_flag_dest,
    input  logic      wb_flag_en,
    output logic      iss_valid,
    output alu_op_e   iss_op,
    output logic      iss_imm_sel,
    output imm_t      iss_imm,
    output hw_t       iss_hw,
    output logic      iss_set_nzcv,
    output preg_idx_t iss_src1,
    output preg_idx_t iss_src2,
    output preg_idx_t iss_old_dest,
    output preg_idx_t iss_dest,
    output flag_idx_t iss_flag_src,
    output flag_idx_t iss_flag_dest,
    output rob_ptr_t  iss_rob_ptr
);
    localparam int unsigned iq_depth = `ALU_IQ_DEPTH;
    localparam int unsigned ptr_w = $clog2(iq_depth);

    alu_op_e   q_op        [iq_depth];
    logic      q_imm_sel   [iq_depth];
    imm_t      q_imm       [iq_depth];
    hw_t       q_hw        [iq_depth];
    logic      q_set_nzcv  [iq_depth];
    preg_idx_t q_src1      [iq_depth];
    preg_idx_t q_src2      [iq_depth];
    preg_idx_t q_old_dest  [iq_depth];
    preg_idx_t q_dest      [iq_depth];
    flag_idx_t q_flag_src  [iq_depth];
    flag_idx_t q_flag_dest [iq_depth];
    rob_ptr_t  q_rob_ptr   [iq_depth];

    logic [ptr_w-1:0] head_ptr;
    logic [ptr_w-1:0] tail_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;
    logic [2:0]       src_hit;
    logic             flag_hit;
    iq_state_e        head_state;

    assign disp_ready = (count != (ptr_w + 1)'(iq_depth));
    assign push = disp_valid && disp_ready;

    // a source is busy while its producer sits in the issue or writeback register
    always_comb begin
        src_hit[0] = (iss_valid && iss_dest == q_src1[head_ptr])
                  || (wb_valid && wb_dest == q_src1[head_ptr]);
        src_hit[1] = !q_imm_sel[head_ptr]
                  && ((iss_valid && iss_dest == q_src2[head_ptr])
                  || (wb_valid && wb_dest == q_src2[head_ptr]));
        src_hit[2] = (q_op[head_ptr] == op_ubfm || q_op[head_ptr] == op_movk)
                  && ((iss_valid && iss_dest == q_old_dest[head_ptr])
                  || (wb_valid && wb_dest == q_old_dest[head_ptr]));
        flag_hit = (iss_valid && iss_set_nzcv && iss_flag_dest == q_flag_src[head_ptr])
                || (wb_flag_en && wb_flag_dest == q_flag_src[head_ptr]);
    end

    always_comb begin
        if (count == '0) begin
            head_state = iq_empty;
        end else if (|src_hit || flag_hit) begin
            head_state = iq_stall;
        end else begin
            head_state = iq_issue;
        end
    end

    assign pop = (head_state == iq_issue);

    always_ff @(posedge clk_in) begin
        if (push) begin
            q_op[tail_ptr]        <= disp_op;
            q_imm_sel[tail_ptr]   <= disp_imm_sel;
            q_imm[tail_ptr]       <= disp_imm;
            q_hw[tail_ptr]        <= disp_hw;
            q_set_nzcv[tail_ptr]  <= disp_set_nzcv;
            q_src1[tail_ptr]      <= disp_src1;
            q_src2[tail_ptr]      <= disp_src2;
            q_old_dest[tail_ptr]  <= disp_old_dest;
            q_dest[tail_ptr]      <= disp_dest;
            q_flag_src[tail_ptr]  <= disp_flag_src;
            q_flag_dest[tail_ptr] <= disp_flag_dest;
            q_rob_ptr[tail_ptr]   <= disp_rob_ptr;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count     <= '0;
            iss_valid <= 1'b0;
        end else begin
            if (push) begin
                tail_ptr <= (tail_ptr == ptr_w'(iq_depth - 1)) ? '0 : tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= (head_ptr == ptr_w'(iq_depth - 1)) ? '0 : head_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            iss_valid <= pop;
        end
    end

    // the issue register only needs a fresh payload when the head leaves
    always_ff @(posedge clk_in) begin
        if (pop) begin
            iss_op        <= q_op[head_ptr];
            iss_imm_sel   <= q_imm_sel[head_ptr];
            iss_imm       <= q_imm[head_ptr];
            iss_hw        <= q_hw[head_ptr];
            iss_set_nzcv  <= q_set_nzcv[head_ptr];
            iss_src1      <= q_src1[head_ptr];
            iss_src2      <= q_src2[head_ptr];
            iss_old_dest  <= q_old_dest[head_ptr];
            iss_dest      <= q_dest[head_ptr];
            iss_flag_src  <= q_flag_src[head_ptr];
            iss_flag_dest <= q_flag_dest[head_ptr];
            iss_rob_ptr   <= q_rob_ptr[head_ptr];
        end
    end

endmodule

`default_nettype wire

/* phys_reg_file.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"
`default_nettype none

module phys_reg_file import alu_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  preg_idx_t rd0_idx,
    input  preg_idx_t rd1_idx,
    input  preg_idx_t rd2_idx,
    output word_t     rd0_data,
    output word_t     rd1_data,
    output word_t     rd2_data,
    input  logic      alu_wr_en,
    input  preg_idx_t alu_wr_idx,
    input  word_t     alu_wr_data,
    input  logic      ext_wr_en,
    input  preg_idx_t ext_wr_idx,
    input  word_t     ext_wr_data
);
    word_t regs [`ALU_NUM_PREGS];

    // reads see the array directly, so a write lands one edge before the next read
    assign rd0_data = regs[rd0_idx];
    assign rd1_data = regs[rd1_idx];
    assign rd2_data = regs[rd2_idx];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            regs <= '{default: '0};
        end else begin
            if (ext_wr_en) begin
                regs[ext_wr_idx] <= ext_wr_data;
            end
            // the ALU port is written last so it wins a clash on the same index
            if (alu_wr_en) begin
                regs[alu_wr_idx] <= alu_wr_data;
            end
        end
    end

endmodule

`default_nettype wire

/* flag_reg_file.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"
`default_nettype none

module flag_reg_file import alu_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  flag_idx_t rd_idx,
    output nzcv_t     rd_data,
    input  logic      wr_en,
    input  flag_idx_t wr_idx,
    input  nzcv_t     wr_data
);
    nzcv_t flags [`ALU_NUM_FLAG_REGS];

    assign rd_data = flags[rd_idx];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            flags <= '{default: '0};
        end else if (wr_en) begin
            flags[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* alu_exec_unit.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"
`default_nettype none

module alu_exec_unit import alu_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  logic      iss_valid,
    input  alu_op_e   iss_op,
    input  logic      iss_imm_sel,
    input  imm_t      iss_imm,
    input  hw_t       iss_hw,
    input  logic      iss_set_nzcv,
    input  preg_idx_t iss_dest,
    input  flag_idx_t iss_flag_dest,
    input  rob_ptr_t  iss_rob_ptr,
    input  word_t     r0_val,
    input  word_t     r1_val,
    input  word_t     r2_val,
    input  nzcv_t     flags_in,
    output logic      wb_valid,
    output rob_ptr_t  wb_rob_ptr,
    output preg_idx_t wb_dest,
    output logic      rf_wr_en,
    output word_t     rf_wr_data,
    output logic      flag_wr_en,
    output flag_idx_t flag_wr_idx,
    output nzcv_t     flag_wr_data
);
    localparam int unsigned msb = `ALU_XLEN - 1;
    localparam word_t all_ones = '1;

    word_t            opb;
    logic [msb+1:0]   add_ext;
    word_t            sub_res;
    logic [6:0]       ubfm_width;
    word_t            ubfm_mask;
    logic [5:0]       hw_shift;
    word_t            result;
    nzcv_t            nzcv;

    assign opb = iss_imm_sel ? word_t'(iss_imm) : r2_val;
    assign add_ext = {1'b0, r1_val} + {1'b0, opb};
    assign sub_res = r1_val - opb;
    assign hw_shift = {iss_hw, 4'b0000};

    // field width is high minus low plus one, which can reach the full 64 bits
    assign ubfm_width = {1'b0, iss_imm[11:6]} - {1'b0, iss_imm[5:0]} + 7'd1;
    assign ubfm_mask = ~(all_ones << ubfm_width);

    always_comb begin
        case (iss_op)
            op_add:  result = add_ext[msb:0];
            op_sub:  result = sub_res;
            op_and:  result = r1_val & opb;
            op_orr:  result = r1_val | opb;
            op_eor:  result = r1_val ^ opb;
            op_mvn:  result = ~r1_val;
            op_ubfm: begin
                if (iss_imm[11:6] < iss_imm[5:0]) begin
                    result = '0;
                end else begin
                    result = (r0_val >> iss_imm[5:0]) & ubfm_mask;
                end
            end
            op_asr:  result = word_t'($signed(r1_val) >>> opb[5:0]);
            op_movz: result = opb << hw_shift;
            op_movk: result = (r0_val & ~(word_t'(16'hffff) << hw_shift))
                            | (word_t'(iss_imm) << hw_shift);
            default: result = '0;
        endcase
    end

    always_comb begin
        nzcv[0] = result[msb];
        nzcv[1] = (result == '0);
        // logical ops and moves keep the incoming carry and overflow
        nzcv[2] = flags_in[2];
        nzcv[3] = flags_in[3];
        if (iss_op == op_add) begin
            nzcv[2] = add_ext[msb+1];
            nzcv[3] = ~(r1_val[msb] ^ opb[msb]) & (r1_val[msb] ^ result[msb]);
        end else if (iss_op == op_sub) begin
            nzcv[2] = (r1_val >= opb);
            nzcv[3] = (r1_val[msb] ^ opb[msb]) & (r1_val[msb] ^ result[msb]);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            wb_valid   <= 1'b0;
            rf_wr_en   <= 1'b0;
            flag_wr_en <= 1'b0;
        end else begin
            wb_valid   <= iss_valid;
            rf_wr_en   <= iss_valid;
            flag_wr_en <= iss_valid && iss_set_nzcv;
        end
    end

    always_ff @(posedge clk_in) begin
        wb_rob_ptr   <= iss_rob_ptr;
        wb_dest      <= iss_dest;
        rf_wr_data   <= result;
        flag_wr_idx  <= iss_flag_dest;
        flag_wr_data <= nzcv;
    end

endmodule

`default_nettype wire

/* alu_cluster_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cluster_top import alu_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  logic      disp_valid,
    input  alu_op_e   disp_op,
    input  logic      disp_imm_sel,
    input  imm_t      disp_imm,
    input  hw_t       disp_hw,
    input  logic      disp_set_nzcv,
    input  preg_idx_t disp_src1,
    input  preg_idx_t disp_src2,
    input  preg_idx_t disp_old_dest,
    input  preg_idx_t disp_dest,
    input  flag_idx_t disp_flag_src,
    input  flag_idx_t disp_flag_dest,
    input  rob_ptr_t  disp_rob_ptr,
    output logic      disp_ready,
    input  logic      ext_wr_en,
    input  preg_idx_t ext_wr_idx,
    input  word_t     ext_wr_data,
    output logic      wb_valid,
    output rob_ptr_t  wb_rob_ptr,
    output logic      rf_wr_en,
    output preg_idx_t rf_wr_idx,
    output word_t     rf_wr_data,
    output logic      flag_wr_en,
    output flag_idx_t flag_wr_idx,
    output nzcv_t     flag_wr_data
);
    logic      iss_valid;
    alu_op_e   iss_op;
    logic      iss_imm_sel;
    imm_t      iss_imm;
    hw_t       iss_hw;
    logic      iss_set_nzcv;
    preg_idx_t iss_src1;
    preg_idx_t iss_src2;
    preg_idx_t iss_old_dest;
    preg_idx_t iss_dest;
    flag_idx_t iss_flag_src;
    flag_idx_t iss_flag_dest;
    rob_ptr_t  iss_rob_ptr;
    word_t     r0_val;
    word_t     r1_val;
    word_t     r2_val;
    nzcv_t     flags_rd;

    alu_issue_queue u_iq (
        .clk_in        (clk_in),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_imm_sel  (disp_imm_sel),
        .disp_imm      (disp_imm),
        .disp_hw       (disp_hw),
        .disp_set_nzcv (disp_set_nzcv),
        .disp_src1     (disp_src1),
        .disp_src2     (disp_src2),
        .disp_old_dest (disp_old_dest),
        .disp_dest     (disp_dest),
        .disp_flag_src (disp_flag_src),
        .disp_flag_dest(disp_flag_dest),
        .disp_rob_ptr  (disp_rob_ptr),
        .disp_ready    (disp_ready),
        .wb_valid      (wb_valid),
        .wb_dest       (rf_wr_idx),
        .wb_flag_dest  (flag_wr_idx),
        .wb_flag_en    (flag_wr_en),
        .iss_valid     (iss_valid),
        .iss_op        (iss_op),
        .iss_imm_sel   (iss_imm_sel),
        .iss_imm       (iss_imm),
        .iss_hw        (iss_hw),
        .iss_set_nzcv  (iss_set_nzcv),
        .iss_src1      (iss_src1),
        .iss_src2      (iss_src2),
        .iss_old_dest  (iss_old_dest),
        .iss_dest      (iss_dest),
        .iss_flag_src  (iss_flag_src),
        .iss_flag_dest (iss_flag_dest),
        .iss_rob_ptr   (iss_rob_ptr)
    );

    // read port 0 serves the old destination that UBFM and MOVK merge into
    phys_reg_file u_prf (
        .clk_in     (clk_in),
        .rst        (rst),
        .rd0_idx    (iss_old_dest),
        .rd1_idx    (iss_src1),
        .rd2_idx    (iss_src2),
        .rd0_data   (r0_val),
        .rd1_data   (r1_val),
        .rd2_data   (r2_val),
        .alu_wr_en  (rf_wr_en),
        .alu_wr_idx (rf_wr_idx),
        .alu_wr_data(rf_wr_data),
        .ext_wr_en  (ext_wr_en),
        .ext_wr_idx (ext_wr_idx),
        .ext_wr_data(ext_wr_data)
    );

    flag_reg_file u_frf (
        .clk_in (clk_in),
        .rst    (rst),
        .rd_idx (iss_flag_src),
        .rd_data(flags_rd),
        .wr_en  (flag_wr_en),
        .wr_idx (flag_wr_idx),
        .wr_data(flag_wr_data)
    );

    alu_exec_unit u_alu (
        .clk_in       (clk_in),
        .rst          (rst),
        .iss_valid    (iss_valid),
        .iss_op       (iss_op),
        .iss_imm_sel  (iss_imm_sel),
        .iss_imm      (iss_imm),
        .iss_hw       (iss_hw),
        .iss_set_nzcv (iss_set_nzcv),
        .iss_dest     (iss_dest),
        .iss_flag_dest(iss_flag_dest),
        .iss_rob_ptr  (iss_rob_ptr),
        .r0_val       (r0_val),
        .r1_val       (r1_val),
        .r2_val       (r2_val),
        .flags_in     (flags_rd),
        .wb_valid     (wb_valid),
        .wb_rob_ptr   (wb_rob_ptr),
        .wb_dest      (rf_wr_idx),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_data   (rf_wr_data),
        .flag_wr_en   (flag_wr_en),
        .flag_wr_idx  (flag_wr_idx),
        .flag_wr_data (flag_wr_data)
    );

endmodule

`default_nettype wire

/* tb_alu_cluster.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"
`default_nettype none

module tb_alu_cluster import alu_pkg::*; ();
    localparam int num_ops = 300;
    localparam int wd_cycles = num_ops * 6 + 100;
    localparam int msb = `ALU_XLEN - 1;

    logic      clk_in;
    logic      rst;
    logic      disp_valid;
    alu_op_e   disp_op;
    logic      disp_imm_sel;
    imm_t      disp_imm;
    hw_t       disp_hw;
    logic      disp_set_nzcv;
    preg_idx_t disp_src1;
    preg_idx_t disp_src2;
    preg_idx_t disp_old_dest;
    preg_idx_t disp_dest;
    flag_idx_t disp_flag_src;
    flag_idx_t disp_flag_dest;
    rob_ptr_t  disp_rob_ptr;
    logic      disp_ready;
    logic      ext_wr_en;
    preg_idx_t ext_wr_idx;
    word_t     ext_wr_data;
    logic      wb_valid;
    rob_ptr_t  wb_rob_ptr;
    logic      rf_wr_en;
    preg_idx_t rf_wr_idx;
    word_t     rf_wr_data;
    logic      flag_wr_en;
    flag_idx_t flag_wr_idx;
    nzcv_t     flag_wr_data;

    integer    seed = 32'h3a23_7681;
    int        err_count = 0;
    int        sent_count = 0;
    int        done_count = 0;
    logic      saw_full = 1'b0;
    rob_ptr_t  next_rob = '0;

    // shadow state holds the architectural view after every dispatched micro-op
    word_t     shadow_regs [`ALU_NUM_PREGS];
    nzcv_t     shadow_flags [`ALU_NUM_FLAG_REGS];

    word_t     exp_data_q [$];
    preg_idx_t exp_dest_q [$];
    rob_ptr_t  exp_rob_q [$];
    logic      exp_fen_q [$];
    nzcv_t     exp_nzcv_q [$];
    flag_idx_t exp_fidx_q [$];

    word_t     got_exp_data;
    preg_idx_t got_exp_dest;
    rob_ptr_t  got_exp_rob;
    logic      got_exp_fen;
    nzcv_t     got_exp_nzcv;
    flag_idx_t got_exp_fidx;

    alu_cluster_top UUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_preg(input string name, input preg_idx_t got, input preg_idx_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_rob(input string name, input rob_ptr_t got, input rob_ptr_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_nzcv(input string name, input nzcv_t got, input nzcv_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag_idx(input string name, input flag_idx_t got, input flag_idx_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("%s", what);
        err_count++;
    endtask

    function automatic word_t model_result(input alu_op_e op, input word_t a, input word_t b,
                                           input word_t r0, input imm_t imm, input hw_t hw);
        word_t v;
        int    lo;
        int    hi;
        int    i;
        lo = imm[5:0];
        hi = imm[11:6];
        v = '0;
        case (op)
            op_add:  v = a + b;
            op_sub:  v = a - b;
            op_and:  v = a & b;
            op_orr:  v = a | b;
            op_eor:  v = a ^ b;
            op_mvn:  v = ~a;
            op_ubfm: begin
                if (hi >= lo) begin
                    v = r0 >> lo;
                    for (i = hi - lo + 1; i <= msb; i++) begin
                        v[i] = 1'b0;
                    end
                end
            end
            op_asr:  v = $signed(a) >>> b[5:0];
            op_movz: v = b << (16 * hw);
            op_movk: begin
                v = r0;
                for (i = 0; i < 16; i++) begin
                    v[16 * hw + i] = imm[i];
                end
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic nzcv_t model_flags(input alu_op_e op, input word_t a, input word_t b,
                                          input word_t res, input nzcv_t old);
        nzcv_t       f;
        logic [msb+1:0] sum;
        f[0] = res[msb];
        f[1] = (res == '0);
        f[2] = old[2];
        f[3] = old[3];
        if (op == op_add) begin
            sum = {1'b0, a} + {1'b0, b};
            f[2] = sum[msb+1];
            f[3] = (a[msb] == b[msb]) && (res[msb] != a[msb]);
        end else if (op == op_sub) begin
            f[2] = (a >= b);
            f[3] = (a[msb] != b[msb]) && (res[msb] != a[msb]);
        end
        return f;
    endfunction

    // waits for room, drives one micro-op for a cycle and records what it must produce
    task automatic dispatch_uop(input alu_op_e op, input logic imm_sel, input imm_t imm,
                                input hw_t hw, input logic set_nzcv, input preg_idx_t src1,
                                input preg_idx_t src2, input preg_idx_t old_dest,
                                input preg_idx_t dest, input flag_idx_t fsrc,
                                input flag_idx_t fdest);
        word_t b;
        word_t res;
        nzcv_t nz;
        while (!disp_ready) begin
            saw_full = 1'b1;
            @(posedge clk_in);
            #5;
        end
        disp_valid = 1'b1;
        disp_op = op;
        disp_imm_sel = imm_sel;
        disp_imm = imm;
        disp_hw = hw;
        disp_set_nzcv = set_nzcv;
        disp_src1 = src1;
        disp_src2 = src2;
        disp_old_dest = old_dest;
        disp_dest = dest;
        disp_flag_src = fsrc;
        disp_flag_dest = fdest;
        disp_rob_ptr = next_rob;
        b = imm_sel ? word_t'(imm) : shadow_regs[src2];
        res = model_result(op, shadow_regs[src1], b, shadow_regs[old_dest], imm, hw);
        nz = model_flags(op, shadow_regs[src1], b, res, shadow_flags[fsrc]);
        exp_data_q.push_back(res);
        exp_dest_q.push_back(dest);
        exp_rob_q.push_back(next_rob);
        exp_fen_q.push_back(set_nzcv);
        exp_nzcv_q.push_back(nz);
        exp_fidx_q.push_back(fdest);
        shadow_regs[dest] = res;
        if (set_nzcv) begin
            shadow_flags[fdest] = nz;
        end
        next_rob = next_rob + rob_ptr_t'(1);
        sent_count++;
        @(posedge clk_in);
        #5;
        disp_valid = 1'b0;
    endtask

    task automatic preload_regs();
        logic [31:0] hi_w;
        logic [31:0] lo_w;
        int          i;
        for (i = 0; i < `ALU_NUM_PREGS; i++) begin
            hi_w = $random(seed);
            lo_w = $random(seed);
            ext_wr_en = 1'b1;
            ext_wr_idx = preg_idx_t'(i);
            ext_wr_data = {hi_w, lo_w};
            shadow_regs[i] = {hi_w, lo_w};
            @(posedge clk_in);
            #5;
        end
        ext_wr_en = 1'b0;
    endtask

    task automatic wait_drain();
        while (done_count != sent_count) begin
            @(posedge clk_in);
            #5;
        end
    endtask

    // outputs settle after the rising edge, so completions are checked on the falling one
    always @(negedge clk_in) begin
        if (!rst) begin
            if (rf_wr_en !== wb_valid) begin
                report_fault("register write strobe does not match the completion pulse");
            end
            if (wb_valid && exp_rob_q.size() == 0) begin
                report_fault("completion seen with no micro-op outstanding");
            end else if (wb_valid) begin
                got_exp_data = exp_data_q.pop_front();
                got_exp_dest = exp_dest_q.pop_front();
                got_exp_rob = exp_rob_q.pop_front();
                got_exp_fen = exp_fen_q.pop_front();
                got_exp_nzcv = exp_nzcv_q.pop_front();
                got_exp_fidx = exp_fidx_q.pop_front();
                check_rob("wb_rob_ptr", wb_rob_ptr, got_exp_rob);
                check_preg("rf_wr_idx", rf_wr_idx, got_exp_dest);
                check_word("rf_wr_data", rf_wr_data, got_exp_data);
                if (flag_wr_en && !got_exp_fen) begin
                    report_fault("flag write seen for a micro-op that does not set flags");
                end else if (!flag_wr_en && got_exp_fen) begin
                    report_fault("flag write missing for a micro-op that sets flags");
                end else if (got_exp_fen) begin
                    check_flag_idx("flag_wr_idx", flag_wr_idx, got_exp_fidx);
                    check_nzcv("flag_wr_data", flag_wr_data, got_exp_nzcv);
                end
                done_count++;
            end else if (flag_wr_en) begin
                report_fault("flag write seen without a completion pulse");
            end
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk_in);
        $display("timeout after %0d cycles with %0d of %0d micro-ops done",
                 wd_cycles, done_count, sent_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] ctl;
        logic [31:0] ops;
        logic [7:0]  sel;
        preg_idx_t   last_dest;
        flag_idx_t   last_fdest;
        preg_idx_t   s1;
        preg_idx_t   s2;
        preg_idx_t   s0;
        flag_idx_t   fs;
        int          n;
        int          i;

        rst = 1'b1;
        disp_valid = 1'b0;
        disp_op = op_add;
        disp_imm_sel = 1'b0;
        disp_imm = '0;
        disp_hw = '0;
        disp_set_nzcv = 1'b0;
        disp_src1 = '0;
        disp_src2 = '0;
        disp_old_dest = '0;
        disp_dest = '0;
        disp_flag_src = '0;
        disp_flag_dest = '0;
        disp_rob_ptr = '0;
        ext_wr_en = 1'b0;
        ext_wr_idx = '0;
        ext_wr_data = '0;
        for (i = 0; i < `ALU_NUM_PREGS; i++) begin
            shadow_regs[i] = '0;
        end
        for (i = 0; i < `ALU_NUM_FLAG_REGS; i++) begin
            shadow_flags[i] = '0;
        end
        last_dest = '0;
        last_fdest = '0;

        repeat (2) @(posedge clk_in);
        #5;
        rst = 1'b0;
        @(negedge clk_in);
        if (wb_valid !== 1'b0 || rf_wr_en !== 1'b0 || flag_wr_en !== 1'b0) begin
            report_fault("write strobes are not low right after reset");
        end
        @(posedge clk_in);
        #5;

        // registers and flags are still cleared here, so this result must be zero
        dispatch_uop(op_orr, 1'b0, '0, '0, 1'b1, 5'd1, 5'd2, 5'd0, 5'd3, 3'd1, 3'd2);
        wait_drain();
        preload_regs();

        for (n = 0; n < num_ops; n++) begin
            ctl = $random(seed);
            ops = $random(seed);
            sel = ctl[7:0] % 8'd10;
            s1 = ctl[16] ? last_dest : ops[20:16];
            s2 = ctl[17] ? last_dest : ops[25:21];
            s0 = ctl[18] ? last_dest : ops[30:26];
            fs = ctl[19] ? last_fdest : ctl[26:24];
            dispatch_uop(alu_op_e'(sel[3:0]), ctl[8], ops[15:0], ctl[11:10], ctl[9],
                         s1, s2, s0, ctl[31:27], fs, ctl[14:12]);
            last_dest = ctl[31:27];
            if (ctl[9]) begin
                last_fdest = ctl[14:12];
            end
            if (ctl[22:20] == 3'd0) begin
                @(posedge clk_in);
                #5;
            end
        end

        wait_drain();
        repeat (5) @(posedge clk_in);
        if (!saw_full) begin
            report_fault("the issue queue never filled, so dispatch back-pressure was not seen");
        end

        $display("%0d micro-ops checked, %0d errors", done_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
alu_pkg.sv
alu_issue_queue.sv
phys_reg_file.sv
flag_reg_file.sv
alu_exec_unit.sv
alu_cluster_top.sv
tb_alu_cluster.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f vlog.f \
    --top-module tb_alu_cluster -o tb_sim &&
sim_out=$(./obj_dir/tb_sim) &&
echo "$sim_out" &&
echo "$sim_out" | grep -q "^TB PASSED$" || exit 1
